// File: verilog.f
design/cpu_types_pkg.sv
design/rob_pkg.sv
design/rob_buffer.sv
design/preg_ready_table.sv
design/retire_unit.sv
design/rob_top.sv
testbench/rob_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the reorder buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=rob_sim

verilator --binary -sv --top-module rob_tb -f verilog.f -o "$BIN"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
    echo "failure reported, see $LOG"
    exit 1
fi

exit 0

// File: testbench/rob_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rob_tb
    import cpu_types_pkg::*;
();

    localparam int ROB_DEPTH = 16;
    localparam int NUM_ROWS  = 24;

    logic  clk;
    logic  rstn;
    logic  disp_valid;
    logic  disp_ready;
    pc_t   disp_pc;
    areg_t disp_arch_reg;
    preg_t disp_dest_preg;
    preg_t disp_old_preg;
    logic  cmpl0_valid;
    preg_t cmpl0_preg;
    word_t cmpl0_data;
    logic  cmpl1_valid;
    preg_t cmpl1_preg;
    word_t cmpl1_data;
    logic [NUM_PREGS-1:0] preg_ready;
    logic  ret0_valid;
    pc_t   ret0_pc;
    areg_t ret0_arch_reg;
    word_t ret0_value;
    preg_t ret0_free_preg;
    logic  ret1_valid;
    pc_t   ret1_pc;
    areg_t ret1_arch_reg;
    word_t ret1_value;
    preg_t ret1_free_preg;

    // stimulus table, one row per instruction
    pc_t   row_pc    [NUM_ROWS];
    areg_t row_arch  [NUM_ROWS];
    preg_t row_dest  [NUM_ROWS];
    preg_t row_old   [NUM_ROWS];
    word_t row_value [NUM_ROWS];
    int    row_delay [NUM_ROWS];   // 0 means drawn at random
    bit    row_burst [NUM_ROWS];

    int countdown [NUM_ROWS];
    bit pending   [NUM_ROWS];
    int ret_q [$];                       // program order, dispatched and not retired
    logic [NUM_PREGS-1:0] ready_model;

    int next_row;
    int cmpl0_row;
    int cmpl1_row;
    bit disp_will_fire;
    bit exp_ret0;
    bit exp_ret1;
    bit released;
    bit full_seen;
    bit finished;
    int error_count;
    int check_count;
    int retired_count;
    int dual_count;
    int cycle_count;
    int cycle_limit;
    int max_delay;
    integer seed;

    rob_top #(
        .ROB_DEPTH(ROB_DEPTH)
    ) dut_i (
        .clk(clk), .rstn(rstn),
        .disp_valid(disp_valid), .disp_ready(disp_ready), .disp_pc(disp_pc),
        .disp_arch_reg(disp_arch_reg), .disp_dest_preg(disp_dest_preg),
        .disp_old_preg(disp_old_preg),
        .cmpl0_valid(cmpl0_valid), .cmpl0_preg(cmpl0_preg), .cmpl0_data(cmpl0_data),
        .cmpl1_valid(cmpl1_valid), .cmpl1_preg(cmpl1_preg), .cmpl1_data(cmpl1_data),
        .preg_ready(preg_ready),
        .ret0_valid(ret0_valid), .ret0_pc(ret0_pc), .ret0_arch_reg(ret0_arch_reg),
        .ret0_value(ret0_value), .ret0_free_preg(ret0_free_preg),
        .ret1_valid(ret1_valid), .ret1_pc(ret1_pc), .ret1_arch_reg(ret1_arch_reg),
        .ret1_value(ret1_value), .ret1_free_preg(ret1_free_preg)
    );

    always #50 clk = ~clk;

    // watchdog
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("retirement stalled, run stopped after %0d cycles", cycle_count);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic set_row(input int i, input pc_t pc, input areg_t arch, input preg_t dest,
                           input preg_t old, input word_t value, input int delay,
                           input bit burst);
        row_pc[i]    = pc;
        row_arch[i]  = arch;
        row_dest[i]  = dest;
        row_old[i]   = old;
        row_value[i] = value;
        row_delay[i] = delay;
        row_burst[i] = burst;
    endtask

    task automatic fill_table();
        // burst rows first so the buffer fills with nothing complete
        set_row(0,  32'h0000_1000, 5'd1,  6'h20, 6'h01, 32'h1111_0a00, 12, 1'b1);
        set_row(1,  32'h0000_1004, 5'd2,  6'h21, 6'h02, 32'h2222_0b01, 11, 1'b1);
        set_row(2,  32'h0000_1008, 5'd3,  6'h22, 6'h03, 32'h3333_0c02, 10, 1'b1);
        set_row(3,  32'h0000_100c, 5'd4,  6'h23, 6'h04, 32'h4444_0d03, 9,  1'b1);
        set_row(4,  32'h0000_1010, 5'd5,  6'h24, 6'h05, 32'h5555_0e04, 8,  1'b1);
        set_row(5,  32'h0000_1014, 5'd6,  6'h25, 6'h06, 32'h6666_0f05, 7,  1'b1);
        set_row(6,  32'h0000_1018, 5'd1,  6'h26, 6'h20, 32'h7777_1006, 6,  1'b1);
        set_row(7,  32'h0000_101c, 5'd7,  6'h27, 6'h07, 32'h8888_1107, 5,  1'b1);
        set_row(8,  32'h0000_1020, 5'd8,  6'h28, 6'h08, 32'h9999_1208, 4,  1'b1);
        set_row(9,  32'h0000_1024, 5'd2,  6'h29, 6'h21, 32'haaaa_1309, 3,  1'b1);
        set_row(10, 32'h0000_1028, 5'd9,  6'h2a, 6'h09, 32'hbbbb_140a, 2,  1'b1);
        set_row(11, 32'h0000_102c, 5'd10, 6'h2b, 6'h0a, 32'hcccc_150b, 1,  1'b1);
        set_row(12, 32'h0000_1030, 5'd11, 6'h2c, 6'h0b, 32'hdddd_160c, 0,  1'b1);
        set_row(13, 32'h0000_1034, 5'd3,  6'h2d, 6'h22, 32'heeee_170d, 0,  1'b1);
        set_row(14, 32'h0000_1038, 5'd12, 6'h2e, 6'h0c, 32'hffff_180e, 0,  1'b1);
        set_row(15, 32'h0000_103c, 5'd13, 6'h2f, 6'h0d, 32'h0123_190f, 0,  1'b1);
        set_row(16, 32'h0000_1040, 5'd14, 6'h30, 6'h0e, 32'h4567_1a10, 0,  1'b0);
        set_row(17, 32'h0000_1044, 5'd1,  6'h31, 6'h26, 32'h89ab_1b11, 1,  1'b0);
        set_row(18, 32'h0000_1048, 5'd15, 6'h32, 6'h0f, 32'hcdef_1c12, 1,  1'b0);
        set_row(19, 32'h0000_104c, 5'd16, 6'h33, 6'h10, 32'hdead_1d13, 0,  1'b0);
        set_row(20, 32'h0000_1050, 5'd4,  6'h34, 6'h23, 32'hbeef_1e14, 3,  1'b0);
        set_row(21, 32'h0000_1054, 5'd17, 6'h35, 6'h11, 32'hcafe_1f15, 0,  1'b0);
        set_row(22, 32'h0000_1058, 5'd18, 6'h36, 6'h12, 32'hf00d_2016, 2,  1'b0);
        set_row(23, 32'h0000_105c, 5'd5,  6'h37, 6'h24, 32'hface_2117, 1,  1'b0);
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] exp_val,
                                   input logic [63:0] act_val);
        error_count++;
        $display("[FAIL] %s expected %h actual %h", name, exp_val, act_val);
    endtask

    // pops the oldest instruction and compares one retire slot with it
    task automatic compare_retired(input string slot, input pc_t pc, input areg_t arch,
                                   input word_t value, input preg_t free_preg);
        int r;
        r = ret_q.pop_front();
        check_count++;
        if (pc !== row_pc[r]) begin
            report_mismatch({slot, "_pc"}, 64'(row_pc[r]), 64'(pc));
        end
        if (arch !== row_arch[r]) begin
            report_mismatch({slot, "_arch_reg"}, 64'(row_arch[r]), 64'(arch));
        end
        if (value !== row_value[r]) begin
            report_mismatch({slot, "_value"}, 64'(row_value[r]), 64'(value));
        end
        if (free_preg !== row_old[r]) begin
            report_mismatch({slot, "_free_preg"}, 64'(row_old[r]), 64'(free_preg));
        end
    endtask

    // state after the edge just passed
    task automatic observe_edge();
        bit exp_ready;
        check_count++;
        if (ret1_valid === 1'b1 && ret0_valid !== 1'b1) begin
            error_count++;
            $display("ret1_valid went high without ret0_valid");
        end
        if (ret0_valid !== exp_ret0) begin
            report_mismatch("ret0_valid", 64'(exp_ret0), 64'(ret0_valid));
        end
        if (ret1_valid !== exp_ret1) begin
            report_mismatch("ret1_valid", 64'(exp_ret1), 64'(ret1_valid));
        end
        if (exp_ret0) begin
            compare_retired("ret0", ret0_pc, ret0_arch_reg, ret0_value, ret0_free_preg);
        end
        if (exp_ret1) begin
            compare_retired("ret1", ret1_pc, ret1_arch_reg, ret1_value, ret1_free_preg);
        end
        // counted from the retire strobes
        if (ret0_valid === 1'b1) begin
            retired_count++;
        end
        if (ret1_valid === 1'b1) begin
            retired_count++;
            dual_count++;
        end
        if (disp_will_fire) begin
            ret_q.push_back(next_row);
            ready_model[row_dest[next_row]] = 1'b0;   // cleared on the dispatch edge
            pending[next_row] = 1'b1;
            countdown[next_row] = row_delay[next_row];
            next_row++;
        end
        if (cmpl0_row >= 0) begin
            ready_model[row_dest[cmpl0_row]] = 1'b1;
        end
        if (cmpl1_row >= 0) begin
            ready_model[row_dest[cmpl1_row]] = 1'b1;
        end
        if (preg_ready !== ready_model) begin
            report_mismatch("preg_ready", ready_model, preg_ready);
        end
        exp_ready = (ret_q.size() < ROB_DEPTH);
        if (disp_ready !== exp_ready) begin
            report_mismatch("disp_ready", 64'(exp_ready), 64'(disp_ready));
        end
        if (ret_q.size() == ROB_DEPTH) begin
            released = 1'b1;   // burst completions may start
        end
        if (disp_ready === 1'b0) begin
            full_seen = 1'b1;
        end
    endtask

    // inputs for the coming edge
    task automatic drive_cycle();
        disp_will_fire = 1'b0;
        disp_valid = 1'b0;
        if (next_row < NUM_ROWS) begin
            disp_valid     = 1'b1;   // held until accepted
            disp_pc        = row_pc[next_row];
            disp_arch_reg  = row_arch[next_row];
            disp_dest_preg = row_dest[next_row];
            disp_old_preg  = row_old[next_row];
            disp_will_fire = (ret_q.size() < ROB_DEPTH);
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (pending[i] && countdown[i] > 0 && (!row_burst[i] || released)) begin
                countdown[i]--;
            end
        end
        cmpl0_valid = 1'b0;
        cmpl1_valid = 1'b0;
        cmpl0_row = -1;
        cmpl1_row = -1;
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (pending[i] && countdown[i] == 0 && (!row_burst[i] || released)) begin
                if (cmpl0_row < 0) begin
                    cmpl0_row = i;
                    cmpl0_valid = 1'b1;
                    cmpl0_preg = row_dest[i];
                    cmpl0_data = row_value[i];
                    pending[i] = 1'b0;
                end else if (cmpl1_row < 0) begin
                    cmpl1_row = i;
                    cmpl1_valid = 1'b1;
                    cmpl1_preg = row_dest[i];
                    cmpl1_data = row_value[i];
                    pending[i] = 1'b0;
                end   // a third one slips a cycle
            end
        end
        exp_ret0 = 1'b0;
        exp_ret1 = 1'b0;
        if (ret_q.size() >= 1) begin
            exp_ret0 = ready_model[row_dest[ret_q[0]]];
        end
        if (exp_ret0 && ret_q.size() >= 2) begin
            exp_ret1 = ready_model[row_dest[ret_q[1]]];
        end
        finished = (next_row == NUM_ROWS) && (ret_q.size() == 0);
    endtask

    initial begin
        clk = 1'b0;
        rstn = 1'b0;
        disp_valid = 1'b0;
        disp_pc = '0;
        disp_arch_reg = '0;
        disp_dest_preg = '0;
        disp_old_preg = '0;
        cmpl0_valid = 1'b0;
        cmpl0_preg = '0;
        cmpl0_data = '0;
        cmpl1_valid = 1'b0;
        cmpl1_preg = '0;
        cmpl1_data = '0;
        ready_model = '1;
        next_row = 0;
        cmpl0_row = -1;
        cmpl1_row = -1;
        error_count = 0;
        check_count = 0;
        retired_count = 0;
        dual_count = 0;
        cycle_count = 0;
        seed = 32'h427;
        fill_table();
        max_delay = 1;
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (row_delay[i] == 0) begin
                row_delay[i] = 1 + int'($unsigned($random(seed)) % 6);
            end
            if (row_delay[i] > max_delay) begin
                max_delay = row_delay[i];
            end
            pending[i] = 1'b0;
        end
        cycle_limit = NUM_ROWS * max_delay + 200;

        repeat (3) @(posedge clk);
        #1;
        check_count++;
        if (preg_ready !== '1) begin
            report_mismatch("preg_ready", '1, preg_ready);
        end
        if (ret0_valid !== 1'b0 || ret1_valid !== 1'b0) begin
            error_count++;
            $display("a retire valid is high during reset");
        end
        if (disp_ready !== 1'b1) begin
            report_mismatch("disp_ready", 64'h1, 64'(disp_ready));
        end
        if (ret0_pc !== '0 || ret0_value !== '0 || ret1_pc !== '0 || ret1_value !== '0 ||
            ret0_arch_reg !== '0 || ret0_free_preg !== '0 ||
            ret1_arch_reg !== '0 || ret1_free_preg !== '0) begin
            error_count++;
            $display("retire data fields are not zero during reset");
        end
        rstn = 1'b1;

        drive_cycle();
        while (!finished) begin
            @(posedge clk);
            #1;
            observe_edge();
            drive_cycle();
        end

        if (!full_seen) begin
            error_count++;
            $display("disp_ready never dropped while the buffer was full");
        end
        if (dual_count == 0) begin
            error_count++;
            $display("no cycle retired two instructions");
        end
        if (retired_count != NUM_ROWS) begin
            report_mismatch("retired_count", 64'(NUM_ROWS), 64'(retired_count));
        end
        $display("checks %0d, errors %0d, retired %0d, dual retire cycles %0d",
                 check_count, error_count, retired_count, dual_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: design/rob_top.sv
`timescale 1ns/1ps
`default_nettype none

module rob_top
    import cpu_types_pkg::*;
    import rob_pkg::*;
#(
    parameter int ROB_DEPTH = ROB_DEPTH_DEF
) (
    input  wire logic clk,
    input  wire logic rstn,

    // dispatch
    input  wire logic  disp_valid,
    output logic       disp_ready,
    input  wire pc_t   disp_pc,
    input  wire areg_t disp_arch_reg,
    input  wire preg_t disp_dest_preg,
    input  wire preg_t disp_old_preg,

    // completion
    input  wire logic  cmpl0_valid,
    input  wire preg_t cmpl0_preg,
    input  wire word_t cmpl0_data,
    input  wire logic  cmpl1_valid,
    input  wire preg_t cmpl1_preg,
    input  wire word_t cmpl1_data,

    output logic [NUM_PREGS-1:0] preg_ready,   // issue queue wakeup

    // retirement
    output logic  ret0_valid,
    output pc_t   ret0_pc,
    output areg_t ret0_arch_reg,
    output word_t ret0_value,
    output preg_t ret0_free_preg,
    output logic  ret1_valid,
    output pc_t   ret1_pc,
    output areg_t ret1_arch_reg,
    output word_t ret1_value,
    output preg_t ret1_free_preg
);

    logic     disp_fire;
    ret_cnt_t ret_count;

    logic  head0_valid;
    pc_t   head0_pc;
    areg_t head0_arch_reg;
    preg_t head0_dest_preg;
    preg_t head0_old_preg;
    logic  head1_valid;
    pc_t   head1_pc;
    areg_t head1_arch_reg;
    preg_t head1_dest_preg;
    preg_t head1_old_preg;

    preg_t rd0_preg;
    preg_t rd1_preg;
    word_t rd0_value;
    word_t rd1_value;

    assign disp_fire = disp_valid & disp_ready;

    rob_buffer #(
        .ROB_DEPTH(ROB_DEPTH)
    ) rob_buffer_i (
        .clk            (clk),
        .rstn           (rstn),
        .disp_valid     (disp_valid),
        .disp_ready     (disp_ready),
        .disp_pc        (disp_pc),
        .disp_arch_reg  (disp_arch_reg),
        .disp_dest_preg (disp_dest_preg),
        .disp_old_preg  (disp_old_preg),
        .ret_count      (ret_count),
        .head0_valid    (head0_valid),
        .head0_pc       (head0_pc),
        .head0_arch_reg (head0_arch_reg),
        .head0_dest_preg(head0_dest_preg),
        .head0_old_preg (head0_old_preg),
        .head1_valid    (head1_valid),
        .head1_pc       (head1_pc),
        .head1_arch_reg (head1_arch_reg),
        .head1_dest_preg(head1_dest_preg),
        .head1_old_preg (head1_old_preg)
    );

    preg_ready_table preg_ready_table_i (
        .clk           (clk),
        .rstn          (rstn),
        .disp_fire     (disp_fire),
        .disp_dest_preg(disp_dest_preg),
        .cmpl0_valid   (cmpl0_valid),
        .cmpl0_preg    (cmpl0_preg),
        .cmpl0_data    (cmpl0_data),
        .cmpl1_valid   (cmpl1_valid),
        .cmpl1_preg    (cmpl1_preg),
        .cmpl1_data    (cmpl1_data),
        .rd0_preg      (rd0_preg),
        .rd1_preg      (rd1_preg),
        .preg_ready    (preg_ready),
        .rd0_value     (rd0_value),
        .rd1_value     (rd1_value)
    );

    retire_unit retire_unit_i (
        .clk            (clk),
        .rstn           (rstn),
        .head0_valid    (head0_valid),
        .head0_pc       (head0_pc),
        .head0_arch_reg (head0_arch_reg),
        .head0_dest_preg(head0_dest_preg),
        .head0_old_preg (head0_old_preg),
        .head1_valid    (head1_valid),
        .head1_pc       (head1_pc),
        .head1_arch_reg (head1_arch_reg),
        .head1_dest_preg(head1_dest_preg),
        .head1_old_preg (head1_old_preg),
        .preg_ready     (preg_ready),
        .rd0_preg       (rd0_preg),
        .rd1_preg       (rd1_preg),
        .rd0_value      (rd0_value),
        .rd1_value      (rd1_value),
        .ret_count      (ret_count),
        .ret0_valid     (ret0_valid),
        .ret0_pc        (ret0_pc),
        .ret0_arch_reg  (ret0_arch_reg),
        .ret0_value     (ret0_value),
        .ret0_free_preg (ret0_free_preg),
        .ret1_valid     (ret1_valid),
        .ret1_pc        (ret1_pc),
        .ret1_arch_reg  (ret1_arch_reg),
        .ret1_value     (ret1_value),
        .ret1_free_preg (ret1_free_preg)
    );

endmodule

`default_nettype wire

// File: design/retire_unit.sv
`timescale 1ns/1ps
`default_nettype none

module retire_unit
    import cpu_types_pkg::*;
    import rob_pkg::*;
(
    input  wire logic clk,
    input  wire logic rstn,

    // oldest two entries from the buffer
    input  wire logic  head0_valid,
    input  wire pc_t   head0_pc,
    input  wire areg_t head0_arch_reg,
    input  wire preg_t head0_dest_preg,
    input  wire preg_t head0_old_preg,
    input  wire logic  head1_valid,
    input  wire pc_t   head1_pc,
    input  wire areg_t head1_arch_reg,
    input  wire preg_t head1_dest_preg,
    input  wire preg_t head1_old_preg,

    // ready table lookups
    input  wire logic [NUM_PREGS-1:0] preg_ready,
    output preg_t                     rd0_preg,
    output preg_t                     rd1_preg,
    input  wire word_t                rd0_value,
    input  wire word_t                rd1_value,

    output ret_cnt_t ret_count,

    // registered retirement, slot 0 is older
    output logic  ret0_valid,
    output pc_t   ret0_pc,
    output areg_t ret0_arch_reg,
    output word_t ret0_value,
    output preg_t ret0_free_preg,
    output logic  ret1_valid,
    output pc_t   ret1_pc,
    output areg_t ret1_arch_reg,
    output word_t ret1_value,
    output preg_t ret1_free_preg
);

    logic head0_go;
    logic head1_go;

    assign rd0_preg = head0_dest_preg;
    assign rd1_preg = head1_dest_preg;

    // in order: head1 only behind a retiring head0
    assign head0_go = head0_valid & preg_ready[head0_dest_preg];
    assign head1_go = head0_go & head1_valid & preg_ready[head1_dest_preg];

    always_comb begin
        if (head1_go) begin
            ret_count = ret_cnt_t'(2);
        end else if (head0_go) begin
            ret_count = ret_cnt_t'(1);
        end else begin
            ret_count = ret_cnt_t'(0);
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ret0_valid     <= 1'b0;
            ret0_pc        <= '0;
            ret0_arch_reg  <= '0;
            ret0_value     <= '0;
            ret0_free_preg <= '0;
            ret1_valid     <= 1'b0;
            ret1_pc        <= '0;
            ret1_arch_reg  <= '0;
            ret1_value     <= '0;
            ret1_free_preg <= '0;
        end else begin
            ret0_valid <= head0_go;
            ret1_valid <= head1_go;
            if (head0_go) begin
                ret0_pc        <= head0_pc;
                ret0_arch_reg  <= head0_arch_reg;
                ret0_value     <= rd0_value;
                ret0_free_preg <= head0_old_preg;   // mapping being replaced
            end
            if (head1_go) begin
                ret1_pc        <= head1_pc;
                ret1_arch_reg  <= head1_arch_reg;
                ret1_value     <= rd1_value;
                ret1_free_preg <= head1_old_preg;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/preg_ready_table.sv
`timescale 1ns/1ps
`default_nettype none

module preg_ready_table
    import cpu_types_pkg::*;
(
    input  wire logic clk,
    input  wire logic rstn,

    // dispatch clears the new destination
    input  wire logic  disp_fire,
    input  wire preg_t disp_dest_preg,

    // completion broadcast, two ports
    input  wire logic  cmpl0_valid,
    input  wire preg_t cmpl0_preg,
    input  wire word_t cmpl0_data,
    input  wire logic  cmpl1_valid,
    input  wire preg_t cmpl1_preg,
    input  wire word_t cmpl1_data,

    // read ports for retirement
    input  wire preg_t rd0_preg,
    input  wire preg_t rd1_preg,

    output logic [NUM_PREGS-1:0] preg_ready,
    output word_t                rd0_value,
    output word_t                rd1_value
);

    word_t preg_value [NUM_PREGS];

    // ready bits, all set out of reset
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            preg_ready <= '1;
        end else begin
            if (disp_fire) begin
                preg_ready[disp_dest_preg] <= 1'b0;
            end
            if (cmpl0_valid) begin
                preg_ready[cmpl0_preg] <= 1'b1;
            end
            if (cmpl1_valid) begin
                preg_ready[cmpl1_preg] <= 1'b1;
            end
        end
    end

    // result storage
    always_ff @(posedge clk) begin
        if (cmpl0_valid) begin
            preg_value[cmpl0_preg] <= cmpl0_data;
        end
        if (cmpl1_valid) begin
            preg_value[cmpl1_preg] <= cmpl1_data;
        end
    end

    assign rd0_value = preg_value[rd0_preg];
    assign rd1_value = preg_value[rd1_preg];

endmodule

`default_nettype wire

// File: design/rob_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module rob_buffer
    import cpu_types_pkg::*;
    import rob_pkg::*;
#(
    parameter int ROB_DEPTH = ROB_DEPTH_DEF
) (
    input  wire logic clk,
    input  wire logic rstn,

    // dispatch from rename
    input  wire logic  disp_valid,
    output logic       disp_ready,
    input  wire pc_t   disp_pc,
    input  wire areg_t disp_arch_reg,
    input  wire preg_t disp_dest_preg,
    input  wire preg_t disp_old_preg,

    // entries leaving at the head this cycle
    input  wire ret_cnt_t ret_count,

    // two oldest entries
    output logic  head0_valid,
    output pc_t   head0_pc,
    output areg_t head0_arch_reg,
    output preg_t head0_dest_preg,
    output preg_t head0_old_preg,
    output logic  head1_valid,
    output pc_t   head1_pc,
    output areg_t head1_arch_reg,
    output preg_t head1_dest_preg,
    output preg_t head1_old_preg
);

    localparam int IDX_W = $clog2(ROB_DEPTH);
    localparam int CNT_W = IDX_W + 1;

    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [CNT_W-1:0] cnt_t;

    // entry payload
    pc_t   entry_pc   [ROB_DEPTH];
    areg_t entry_arch [ROB_DEPTH];
    preg_t entry_dest [ROB_DEPTH];
    preg_t entry_old  [ROB_DEPTH];

    idx_t head_ptr;
    idx_t tail_ptr;
    idx_t head1_ptr;
    cnt_t occupancy;
    logic disp_fire;

    // room left whenever not completely full
    assign disp_ready = (occupancy < cnt_t'(ROB_DEPTH));
    assign disp_fire  = disp_valid & disp_ready;

    assign head1_ptr = head_ptr + idx_t'(1);   // wraps with the index width

    // head view, validity from occupancy
    assign head0_valid     = (occupancy >= cnt_t'(1));
    assign head0_pc        = entry_pc[head_ptr];
    assign head0_arch_reg  = entry_arch[head_ptr];
    assign head0_dest_preg = entry_dest[head_ptr];
    assign head0_old_preg  = entry_old[head_ptr];

    assign head1_valid     = (occupancy >= cnt_t'(2));
    assign head1_pc        = entry_pc[head1_ptr];
    assign head1_arch_reg  = entry_arch[head1_ptr];
    assign head1_dest_preg = entry_dest[head1_ptr];
    assign head1_old_preg  = entry_old[head1_ptr];

    // entry write at the tail
    always_ff @(posedge clk) begin
        if (disp_fire) begin
            entry_pc[tail_ptr]   <= disp_pc;
            entry_arch[tail_ptr] <= disp_arch_reg;
            entry_dest[tail_ptr] <= disp_dest_preg;
            entry_old[tail_ptr]  <= disp_old_preg;
        end
    end

    // pointers and occupancy
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            head_ptr  <= '0;
            tail_ptr  <= '0;
            occupancy <= '0;
        end else begin
            if (disp_fire) begin
                tail_ptr <= tail_ptr + idx_t'(1);
            end
            head_ptr  <= head_ptr + idx_t'(ret_count);
            // dispatch and retirement can land on the same edge
            occupancy <= occupancy + cnt_t'(disp_fire) - cnt_t'(ret_count);
        end
    end

endmodule

`default_nettype wire

// File: design/rob_pkg.sv
`default_nettype none

package rob_pkg;

    // default reorder buffer size, power of two
    localparam int ROB_DEPTH_DEF = 16;
    localparam int ROB_IDX_W     = $clog2(ROB_DEPTH_DEF);

    typedef logic [ROB_IDX_W-1:0] rob_idx_t;   // entry index at default depth
    typedef logic [ROB_IDX_W:0]   rob_cnt_t;   // occupancy 0..depth

    // retire width, up to two per cycle
    localparam int RET_WIDTH = 2;

    typedef logic [$clog2(RET_WIDTH+1)-1:0] ret_cnt_t;   // 0, 1 or 2

endpackage

`default_nettype wire

// File: design/cpu_types_pkg.sv
`default_nettype none

// widths shared across the whole core
package cpu_types_pkg;

    localparam int XLEN      = 32;   // data word and pc width
    localparam int NUM_AREGS = 32;
    localparam int NUM_PREGS = 64;

    localparam int AREG_W = $clog2(NUM_AREGS);
    localparam int PREG_W = $clog2(NUM_PREGS);

    typedef logic [XLEN-1:0]   word_t;   // result value
    typedef logic [XLEN-1:0]   pc_t;     // instruction address
    typedef logic [AREG_W-1:0] areg_t;   // architectural reg number
    typedef logic [PREG_W-1:0] preg_t;   // physical reg number

endpackage

`default_nettype wire
